// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int XLEN     = 64;
    localparam int ILEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 2 ** REG_AW;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [ILEN-1:0]   inst_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]   pc_t;

    localparam pc_t PC_RESET = 64'h0000_0000_8000_0000;

    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub and sra

    localparam inst_t EBREAK_INST = 32'h0010_0073;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS2   // lui
    } alu_op_e;

endpackage

// ==== rv_pipe_pkg.sv ====
package rv_pipe_pkg;
    import rv_isa_pkg::*;

    localparam int APB_AW   = 12;
    localparam int APB_DW   = 32;
    localparam int RETIRE_W = 16;

    typedef logic [APB_AW-1:0]   apb_addr_t;
    typedef logic [APB_DW-1:0]   apb_data_t;
    typedef logic [RETIRE_W-1:0] retire_cnt_t;

    localparam apb_addr_t ADDR_INSTR    = 12'h000;
    localparam apb_addr_t ADDR_STATUS   = 12'h004;
    localparam apb_addr_t ADDR_PC       = 12'h008;
    localparam apb_addr_t ADDR_REG_BASE = 12'h100;  // 8 bytes per register

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        logic illegal;
        logic ebreak;
    } retire_t;

    typedef struct packed {
        pc_t       pc;
        alu_op_e   alu_op;
        xlen_t     src1;
        xlen_t     src2;
        reg_addr_t rd;
        logic      reg_wen;
        logic      word_op;   // sign-extend from bit 31
        logic      illegal;
        logic      ebreak;
        inst_t     inst;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        retire_t   status;
        reg_addr_t rd;
        logic      reg_wen;
        xlen_t     data;
    } wb_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        WAIT_DRAIN
    } ctrl_state_e;

endpackage

// ==== rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      issue_valid_i,
    input  inst_t     issue_inst_i,
    input  pc_t       issue_pc_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    input  xlen_t     rs1_data_i,
    input  xlen_t     rs2_data_i,
    input  wb_t       wb_i,
    output logic      id_valid_o,
    output id_ex_t    id_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      rs1_val;
    xlen_t      rs2_val;
    logic       wb_fwd;

    assign opcode     = issue_inst_i[6:0];
    assign funct3     = issue_inst_i[14:12];
    assign funct7     = issue_inst_i[31:25];
    assign rs1_addr_o = issue_inst_i[19:15];
    assign rs2_addr_o = issue_inst_i[24:20];
    assign id_valid_o = issue_valid_i;

    assign imm_i = {{52{issue_inst_i[31]}}, issue_inst_i[31:20]};
    assign imm_u = {{32{issue_inst_i[31]}}, issue_inst_i[31:12], 12'b0};

    // result still in write-back, one cycle before the regfile has it
    assign wb_fwd  = wb_i.valid && wb_i.reg_wen && (wb_i.rd != '0);
    assign rs1_val = (wb_fwd && wb_i.rd == rs1_addr_o) ? wb_i.data : rs1_data_i;
    assign rs2_val = (wb_fwd && wb_i.rd == rs2_addr_o) ? wb_i.data : rs2_data_i;

    always_comb begin
        id_o        = '0;
        id_o.pc     = issue_pc_i;
        id_o.inst   = issue_inst_i;
        id_o.rd     = issue_inst_i[11:7];
        id_o.alu_op = ALU_ADD;
        id_o.src1   = rs1_val;
        id_o.src2   = imm_i;
        case (opcode)
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000:  id_o.alu_op = ALU_ADD;
                    3'b001:  id_o.alu_op = ALU_SLL;
                    3'b010:  id_o.alu_op = ALU_SLT;
                    3'b011:  id_o.alu_op = ALU_SLTU;
                    3'b100:  id_o.alu_op = ALU_XOR;
                    3'b101:  id_o.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  id_o.alu_op = ALU_OR;
                    default: id_o.alu_op = ALU_AND;
                endcase
                // rv64 shifts keep a 6-bit shamt, funct6 must be clean
                if (funct3[1:0] == 2'b01 && {funct7[6], funct7[4:1]} != '0) begin
                    id_o.illegal = 1'b1;
                end
                if (funct3 == 3'b001 && funct7[5]) begin
                    id_o.illegal = 1'b1;
                end
            end
            OPC_OP: begin
                id_o.src2 = rs2_val;
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}: id_o.alu_op = ALU_ADD;
                    {F7_ALT,  3'b000}: id_o.alu_op = ALU_SUB;
                    {F7_BASE, 3'b001}: id_o.alu_op = ALU_SLL;
                    {F7_BASE, 3'b010}: id_o.alu_op = ALU_SLT;
                    {F7_BASE, 3'b011}: id_o.alu_op = ALU_SLTU;
                    {F7_BASE, 3'b100}: id_o.alu_op = ALU_XOR;
                    {F7_BASE, 3'b101}: id_o.alu_op = ALU_SRL;
                    {F7_ALT,  3'b101}: id_o.alu_op = ALU_SRA;
                    {F7_BASE, 3'b110}: id_o.alu_op = ALU_OR;
                    {F7_BASE, 3'b111}: id_o.alu_op = ALU_AND;
                    default:           id_o.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM_32: begin
                id_o.word_op = 1'b1;   // addiw only
                id_o.illegal = (funct3 != 3'b000);
            end
            OPC_OP_32: begin
                id_o.src2    = rs2_val;
                id_o.word_op = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}: id_o.alu_op = ALU_ADD;
                    {F7_ALT,  3'b000}: id_o.alu_op = ALU_SUB;
                    default:           id_o.illegal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                id_o.alu_op = ALU_PASS2;
                id_o.src2   = imm_u;
            end
            OPC_AUIPC: begin
                id_o.src1 = issue_pc_i;   // pc of this very instruction
                id_o.src2 = imm_u;
            end
            OPC_SYSTEM: begin
                id_o.ebreak  = (issue_inst_i == EBREAK_INST);
                id_o.illegal = (issue_inst_i != EBREAK_INST);
            end
            default: id_o.illegal = 1'b1;
        endcase
        id_o.reg_wen = !id_o.illegal && !id_o.ebreak;
    end

endmodule

// ==== id_ex_regs.sv ====
`timescale 1ns/1ps

module id_ex_regs
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   id_valid_i,
    input  id_ex_t id_i,
    output logic   ex_valid_o,
    output id_ex_t ex_o
);

    // no stall or flush, loads every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid_o <= 1'b0;
            ex_o       <= '0;
            ex_o.pc    <= PC_RESET;
        end else begin
            ex_valid_o <= id_valid_i;
            ex_o       <= id_i;
        end
    end

endmodule

// ==== rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   ex_valid_i,
    input  id_ex_t ex_i,
    output wb_t    wb_o
);

    logic [5:0] shamt;
    xlen_t      res;
    xlen_t      res_ext;
    logic       wen;

    assign shamt = ex_i.word_op ? {1'b0, ex_i.src2[4:0]} : ex_i.src2[5:0];

    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD:  res = ex_i.src1 + ex_i.src2;
            ALU_SUB:  res = ex_i.src1 - ex_i.src2;
            ALU_SLL:  res = ex_i.src1 << shamt;
            ALU_SLT:  res = xlen_t'($signed(ex_i.src1) < $signed(ex_i.src2));
            ALU_SLTU: res = xlen_t'(ex_i.src1 < ex_i.src2);
            ALU_XOR:  res = ex_i.src1 ^ ex_i.src2;
            ALU_SRL:  res = ex_i.src1 >> shamt;
            ALU_SRA:  res = xlen_t'($signed(ex_i.src1) >>> shamt);
            ALU_OR:   res = ex_i.src1 | ex_i.src2;
            ALU_AND:  res = ex_i.src1 & ex_i.src2;
            default:  res = ex_i.src2;   // pass2
        endcase
    end

    assign res_ext = ex_i.word_op ? {{32{res[31]}}, res[31:0]} : res;

    // x0 and non-writing retires never reach the regfile
    assign wen = ex_valid_i && ex_i.reg_wen && !ex_i.illegal && !ex_i.ebreak
                 && (ex_i.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_o <= '0;
        end else begin
            wb_o.valid          <= ex_valid_i;
            wb_o.rd             <= ex_i.rd;
            wb_o.reg_wen        <= wen;
            wb_o.data           <= res_ext;
            wb_o.status.illegal <= ex_valid_i && ex_i.illegal;
            wb_o.status.ebreak  <= ex_valid_i && ex_i.ebreak;
        end
    end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    input  wb_t       wb_i,
    input  reg_addr_t host_raddr_i,
    output xlen_t     host_rdata_o
);

    xlen_t regs_q [1:NUM_REGS-1];   // x0 not stored
    logic  wr_en;

    assign wr_en = wb_i.valid && wb_i.reg_wen && (wb_i.rd != '0);

    // write-through, a same-cycle write is seen on every read port
    function automatic xlen_t read_port(input reg_addr_t addr);
        xlen_t val;
        if (addr == '0) begin
            val = '0;
        end else if (wr_en && wb_i.rd == addr) begin
            val = wb_i.data;
        end else begin
            val = regs_q[addr];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data_o   = read_port(rs1_addr_i);
        rs2_data_o   = read_port(rs2_addr_i);
        host_rdata_o = read_port(host_raddr_i);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

endmodule

// ==== rv_pipe_ctrl.sv ====
`timescale 1ns/1ps

module rv_pipe_ctrl
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  apb_req_t  apb_req_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    output logic      issue_valid_o,
    output inst_t     issue_inst_o,
    output pc_t       issue_pc_o,
    input  logic      ex_busy_i,
    input  wb_t       wb_i,
    output reg_addr_t host_raddr_o,
    input  xlen_t     host_rdata_i
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    pc_t         pc_q;
    logic        halted_q;
    logic        halt_pend_q;   // ebreak issued, not yet retired
    logic        illegal_q;
    retire_cnt_t retired_q;
    logic        access;
    logic        is_instr;
    logic        is_status;
    logic        is_pc;
    logic        is_reg;
    logic        rd_ok;
    logic        xfer_err;
    logic        pipe_empty;
    logic        instr_accept;
    apb_data_t   rd_word;

    assign access    = apb_req_i.psel && apb_req_i.penable;
    assign is_instr  = (apb_req_i.paddr == ADDR_INSTR);
    assign is_status = (apb_req_i.paddr == ADDR_STATUS);
    assign is_pc     = (apb_req_i.paddr == ADDR_PC);
    assign is_reg    = (apb_req_i.paddr[11:8] == ADDR_REG_BASE[11:8])
                       && (apb_req_i.paddr[1:0] == 2'b00);
    assign rd_ok     = is_status || is_pc || is_reg;
    assign xfer_err  = apb_req_i.pwrite ? (!is_instr || halt_pend_q) : !rd_ok;

    assign pipe_empty   = !issue_valid_o && !ex_busy_i && !wb_i.valid;
    assign instr_accept = (state_q == ACCESS) && access && apb_req_i.pwrite
                          && is_instr && !halt_pend_q;

    assign host_raddr_o = apb_req_i.paddr[7:3];

    always_comb begin
        rd_word = '0;
        if (is_status) begin
            rd_word = {retired_q, 14'b0, illegal_q, halted_q};
        end else if (is_pc) begin
            rd_word = pc_q[31:0];
        end else if (is_reg) begin
            rd_word = apb_req_i.paddr[2] ? host_rdata_i[63:32] : host_rdata_i[31:0];
        end
    end

    always_comb begin
        state_d   = state_q;
        pready_o  = 1'b0;
        pslverr_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (apb_req_i.psel && !apb_req_i.penable) begin
                    state_d = ACCESS;
                end
            end
            ACCESS: begin
                if (access) begin
                    if (!apb_req_i.pwrite && rd_ok && !pipe_empty) begin
                        state_d = WAIT_DRAIN;   // hold read until all retired
                    end else begin
                        pready_o  = 1'b1;
                        pslverr_o = xfer_err;
                        state_d   = IDLE;
                    end
                end
            end
            default: begin
                if (pipe_empty) begin
                    pready_o = 1'b1;
                    state_d  = IDLE;
                end
            end
        endcase
    end

    assign prdata_o = (pready_o && !apb_req_i.pwrite) ? rd_word : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= IDLE;
            pc_q          <= PC_RESET;
            issue_valid_o <= 1'b0;
            issue_inst_o  <= '0;
            issue_pc_o    <= PC_RESET;
            halted_q      <= 1'b0;
            halt_pend_q   <= 1'b0;
            illegal_q     <= 1'b0;
            retired_q     <= '0;
        end else begin
            state_q       <= state_d;
            issue_valid_o <= instr_accept;
            if (instr_accept) begin
                issue_inst_o <= apb_req_i.pwdata;
                issue_pc_o   <= pc_q;
                pc_q         <= pc_q + 64'd4;
                if (apb_req_i.pwdata == EBREAK_INST) begin
                    halt_pend_q <= 1'b1;   // drop writes already in flight window
                end
            end
            if (wb_i.valid) begin
                retired_q <= retired_q + 1'b1;
                if (wb_i.status.illegal) begin
                    illegal_q <= 1'b1;
                end
                if (wb_i.status.ebreak) begin
                    halted_q <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== rv_exec_top.sv ====
`timescale 1ns/1ps

module rv_exec_top
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  apb_req_t  apb_req_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    logic      issue_valid;
    inst_t     issue_inst;
    pc_t       issue_pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t host_raddr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     host_rdata;
    logic      id_valid;
    logic      ex_valid;
    id_ex_t    id_payload;
    id_ex_t    ex_payload;
    wb_t       wb;

    rv_pipe_ctrl i_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .apb_req_i     (apb_req_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .issue_valid_o (issue_valid),
        .issue_inst_o  (issue_inst),
        .issue_pc_o    (issue_pc),
        .ex_busy_i     (ex_valid),
        .wb_i          (wb),
        .host_raddr_o  (host_raddr),
        .host_rdata_i  (host_rdata)
    );

    rv_decoder i_decoder (
        .issue_valid_i (issue_valid),
        .issue_inst_i  (issue_inst),
        .issue_pc_i    (issue_pc),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .wb_i          (wb),
        .id_valid_o    (id_valid),
        .id_o          (id_payload)
    );

    id_ex_regs i_id_ex (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_valid_i (id_valid),
        .id_i       (id_payload),
        .ex_valid_o (ex_valid),
        .ex_o       (ex_payload)
    );

    rv_alu i_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_valid_i (ex_valid),
        .ex_i       (ex_payload),
        .wb_o       (wb)
    );

    rv_regfile i_regfile (
        .clk          (clk),
        .rst_n        (rst_n),
        .rs1_addr_i   (rs1_addr),
        .rs2_addr_i   (rs2_addr),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .wb_i         (wb),
        .host_raddr_i (host_raddr),
        .host_rdata_o (host_rdata)
    );

endmodule

// ==== tb_rv_exec_top.sv ====
`timescale 1ns/1ps

module tb_rv_exec_top
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
();

    localparam int N_ARITH = 200;
    localparam int N_WORD  = 30;
    localparam int N_ILL   = 4;
    localparam int N_RAW   = 8;
    // transfers per test: reset, arith, word ops, illegal, apb errors, halt
    localparam int N_XFERS = 66 + (62 + N_ARITH + 66) + (N_WORD + 7 + 66)
                             + (4 * N_ILL + 1) + (11 + 3 * N_RAW) + 10;
    localparam int WDOG_CYCLES = N_XFERS * 20 + 10;   // plus reset

    logic      clk;
    logic      rst_n;
    apb_req_t  apb_req;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    xlen_t       mregs [0:NUM_REGS-1];   // reference register file
    pc_t         mpc;
    logic        mhalted;
    logic        millegal;
    retire_cnt_t mretired;

    rv_exec_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req_i (apb_req),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    always #20 clk = ~clk;

    task automatic check_val(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
        assert (act === exp) else begin
            $display("error: %s expected 0x%h, got 0x%h", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first error");
        end
    endtask

    function automatic xlen_t sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function automatic inst_t encode(input logic [11:0] hi, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {hi, rs1, f3, rd, opc};   // hi is imm12 or {funct7, rs2}
    endfunction

    function automatic logic opcode_known(input logic [6:0] opc);
        case (opc)
            OPC_OP_IMM, OPC_OP, OPC_OP_IMM_32, OPC_OP_32: return 1'b1;
            OPC_LUI, OPC_AUIPC, OPC_SYSTEM:                return 1'b1;
            default:                                       return 1'b0;
        endcase
    endfunction

    function automatic inst_t rand_illegal();
        inst_t inst;
        inst = $urandom;
        while (opcode_known(inst[6:0])) begin
            inst = $urandom;
        end
        return inst;
    endfunction

    function automatic inst_t rand_arith();
        logic [2:0]  f3;
        logic [5:0]  sh;
        logic [11:0] imm;
        logic [6:0]  f7;
        f3  = 3'($urandom);
        sh  = 6'($urandom);
        imm = 12'($urandom);
        f7  = 7'h00;
        if ($urandom_range(1, 0) == 0) begin
            if (f3 == 3'd1) begin
                imm = {6'b000000, sh};
            end else if (f3 == 3'd5) begin
                imm = {($urandom_range(1, 0) == 1 ? 6'b010000 : 6'b000000), sh};   // srai or srli
            end
            return encode(imm, 5'($urandom), f3, 5'($urandom), OPC_OP_IMM);
        end
        if ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1, 0) == 1) begin
            f7 = 7'h20;   // sub, sra
        end
        return encode({f7, 5'($urandom)}, 5'($urandom), f3, 5'($urandom), OPC_OP);
    endfunction

    // ISA semantics applied in issue order
    task automatic model_exec(input inst_t inst);
        logic [6:0] opc;
        logic [2:0] f3;
        logic       alt;
        logic [5:0] sh;
        xlen_t      a;
        xlen_t      b;
        xlen_t      immi;
        xlen_t      immu;
        xlen_t      val;
        logic       wr;
        opc  = inst[6:0];
        f3   = inst[14:12];
        alt  = inst[30];
        a    = mregs[inst[19:15]];
        b    = mregs[inst[24:20]];
        immi = {{52{inst[31]}}, inst[31:20]};
        immu = {{32{inst[31]}}, inst[31:12], 12'h000};
        val  = '0;
        wr   = 1'b1;
        sh   = (opc == OPC_OP) ? b[5:0] : inst[25:20];
        if (opc == OPC_OP_IMM || opc == OPC_OP) begin
            if (opc == OPC_OP_IMM) begin
                b = immi;
            end
            case (f3)
                3'd0: val = (opc == OPC_OP && alt) ? a - b : a + b;
                3'd1: val = a << sh;
                3'd2: val = {63'd0, $signed(a) < $signed(b)};
                3'd3: val = {63'd0, a < b};
                3'd4: val = a ^ b;
                3'd5: begin
                    if (alt) begin
                        val = $signed(a) >>> sh;
                    end else begin
                        val = a >> sh;
                    end
                end
                3'd6: val = a | b;
                default: val = a & b;
            endcase
        end else if (opc == OPC_OP_IMM_32) begin
            val = sext32(a[31:0] + immi[31:0]);
        end else if (opc == OPC_OP_32) begin
            val = alt ? sext32(a[31:0] - b[31:0]) : sext32(a[31:0] + b[31:0]);
        end else if (opc == OPC_LUI) begin
            val = immu;
        end else if (opc == OPC_AUIPC) begin
            val = mpc + immu;
        end else if (inst == EBREAK_INST) begin
            wr      = 1'b0;
            mhalted = 1'b1;
        end else begin
            wr       = 1'b0;
            millegal = 1'b1;
        end
        if (wr && inst[11:7] != 5'd0) begin
            mregs[inst[11:7]] = val;
        end
        mpc      = mpc + 64'd4;
        mretired = mretired + 1'b1;
    endtask

    task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata, output logic err);
        @(negedge clk);
        apb_req.psel    = 1'b1;   // setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);
        while (!pready) begin
            @(posedge clk);
        end
        rdata = prdata;   // values from before this edge
        err   = pslverr;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, input logic exp_err);
        apb_data_t rdata;
        logic      err;
        apb_transfer(1'b1, addr, wdata, rdata, err);
        check_val("pslverr_o", exp_err, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, input apb_data_t exp_data,
                            input logic exp_err, input string name);
        apb_data_t rdata;
        logic      err;
        apb_transfer(1'b0, addr, '0, rdata, err);
        check_val("pslverr_o", exp_err, err);
        check_val(name, exp_data, rdata);
    endtask

    task automatic issue_inst(input inst_t inst);
        apb_write(ADDR_INSTR, inst, mhalted);   // dropped once halted
        if (!mhalted) begin
            model_exec(inst);
        end
    endtask

    task automatic check_reg(input int n);
        apb_addr_t addr;
        addr = ADDR_REG_BASE + 12'(n * 8);
        apb_read(addr, mregs[n][31:0], 1'b0, $sformatf("prdata_o x%0d low", n));
        apb_read(addr + 12'd4, mregs[n][63:32], 1'b0, $sformatf("prdata_o x%0d high", n));
    endtask

    task automatic check_all_regs();
        for (int n = 0; n < NUM_REGS; n++) begin
            check_reg(n);
        end
    endtask

    task automatic check_status();
        apb_read(ADDR_STATUS, {mretired, 14'b0, millegal, mhalted}, 1'b0, "prdata_o STATUS");
    endtask

    task automatic check_pc();
        apb_read(ADDR_PC, mpc[31:0], 1'b0, "prdata_o PC");
    endtask

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("error: watchdog expired after %0d cycles, a transfer never ended", WDOG_CYCLES);
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

    initial begin
        inst_t     inst;
        reg_addr_t rd;
        reg_addr_t last_rd;
        void'($urandom(32'h9022_ccba));
        clk      = 1'b0;
        rst_n    = 1'b0;
        apb_req  = '0;
        mpc      = PC_RESET;
        mhalted  = 1'b0;
        millegal = 1'b0;
        mretired = '0;
        last_rd  = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            mregs[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        check_val("pready_o", 1'b0, pready);
        check_val("pslverr_o", 1'b0, pslverr);

        check_status();
        check_pc();
        check_all_regs();

        // seed x1..x31, each addi depends on the lui right before it
        for (int n = 1; n < NUM_REGS; n++) begin
            issue_inst({20'($urandom), 5'(n), OPC_LUI});
            issue_inst(encode(12'($urandom), 5'(n), 3'b000, 5'(n), OPC_OP_IMM));
        end
        for (int i = 0; i < N_ARITH; i++) begin
            inst = rand_arith();
            if ($urandom_range(3, 0) == 0) begin
                inst[19:15] = last_rd;   // hits the write-back bypass
            end
            last_rd = inst[11:7];
            issue_inst(inst);
        end
        check_all_regs();
        check_status();
        check_pc();

        for (int i = 0; i < N_WORD; i++) begin
            rd = 5'($urandom_range(31, 1));
            case (i % 3)
                0: inst = encode(12'($urandom), 5'($urandom), 3'b000, rd, OPC_OP_IMM_32);
                1: inst = encode({7'h00, 5'($urandom)}, 5'($urandom), 3'b000, rd, OPC_OP_32);
                default: inst = encode({7'h20, 5'($urandom)}, 5'($urandom), 3'b000, rd,
                                       OPC_OP_32);
            endcase
            issue_inst(inst);
        end
        for (int i = 0; i < 4; i++) begin
            issue_inst({20'($urandom), 5'($urandom_range(31, 1)), OPC_AUIPC});
        end
        issue_inst({20'($urandom), 5'd0, OPC_LUI});   // x0 stays zero
        issue_inst(encode(12'($urandom), 5'd3, 3'b000, 5'd0, OPC_OP_IMM));
        issue_inst(encode({7'h00, 5'd4}, 5'd5, 3'b000, 5'd0, OPC_OP));
        check_all_regs();
        check_status();
        check_pc();

        for (int i = 0; i < N_ILL; i++) begin
            inst = rand_illegal();
            issue_inst(inst);
            check_status();
            check_reg(inst[11:7]);
        end
        check_pc();

        apb_write(ADDR_STATUS, $urandom, 1'b1);
        apb_write(ADDR_PC, $urandom, 1'b1);
        apb_write(ADDR_REG_BASE + 12'h008, $urandom, 1'b1);
        apb_write(12'h00C, $urandom, 1'b1);
        apb_write(12'h300, $urandom, 1'b1);
        apb_write(12'h0FC, $urandom, 1'b1);
        apb_read(ADDR_INSTR, '0, 1'b1, "prdata_o unmapped");
        apb_read(12'h00C, '0, 1'b1, "prdata_o unmapped");
        apb_read(12'h102, '0, 1'b1, "prdata_o unmapped");
        apb_read(12'h400, '0, 1'b1, "prdata_o unmapped");
        check_pc();
        // read right behind the write, must see the retired value
        for (int i = 0; i < N_RAW; i++) begin
            rd = 5'($urandom_range(31, 1));
            issue_inst(encode(12'($urandom), rd, 3'b000, rd, OPC_OP_IMM));
            check_reg(rd);
        end

        issue_inst(EBREAK_INST);
        check_status();
        for (int i = 0; i < 4; i++) begin
            issue_inst(encode(12'h001, 5'd7, 3'b000, 5'd7, OPC_OP_IMM));   // addi x7 dropped
        end
        check_pc();
        check_status();
        check_reg(7);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== build.f ====
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_decoder.sv
id_ex_regs.sv
rv_alu.sv
rv_regfile.sv
rv_pipe_ctrl.sv
rv_exec_top.sv
tb_rv_exec_top.sv

// ==== Bender.yml ====
package:
  name: rv_exec_slice

sources:
  - rv_isa_pkg.sv
  - rv_pipe_pkg.sv
  - rv_decoder.sv
  - id_ex_regs.sv
  - rv_alu.sv
  - rv_regfile.sv
  - rv_pipe_ctrl.sv
  - rv_exec_top.sv
  - target: test
    files:
      - tb_rv_exec_top.sv
